// File: lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// Byte address of the first fetch.
`define PC_RESET 16'h0000

// Instruction memory size in 16-bit words.
`define IMEM_DEPTH 256

// Word address width of the instruction memory.
`define IMEM_AW 8

`endif

// File: lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// ########################################
	// Instruction word views

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [1:0] zero;
		lc3b_reg sr2;
	} lc3b_reg_form;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] imm5;
	} lc3b_imm_form;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_nzp nzp;
		logic [8:0] offset9;
	} lc3b_br_form;

	typedef union packed {
		lc3b_reg_form rform;
		lc3b_imm_form iform;
		lc3b_br_form br;
	} lc3b_instr;

	typedef struct packed {
		lc3b_aluop aluop;
		logic srcb_imm_sel;
		logic load_regfile;
		logic load_cc;
		logic is_branch;
	} lc3b_control;

endpackage

// File: id_ex_if.sv
interface id_ex_if
	import lc3b_types::*;
();

	logic valid;
	lc3b_word pc;	// Fetch address plus 2.
	lc3b_instr instr;
	lc3b_control ctrl;
	lc3b_word srca;
	lc3b_word srcb;

	modport producer (
		output valid,
		output pc,
		output instr,
		output ctrl,
		output srca,
		output srcb
	);

	modport consumer (
		input valid,
		input pc,
		input instr,
		input ctrl,
		input srca,
		input srcb
	);

endinterface

// File: fetch.sv
`include "lc3b_cfg.svh"

module fetch
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic imem_we,
	input logic [`IMEM_AW-1:0] imem_addr,
	input lc3b_word imem_data,
	input logic redirect,
	input lc3b_word redirect_pc,
	output logic if_id_valid,
	output lc3b_word if_id_pc,
	output lc3b_instr if_id_instr
);

	lc3b_word pc;
	lc3b_word pc_next;
	lc3b_word fetch_word;
	lc3b_word imem [`IMEM_DEPTH];

	assign pc_next = pc + 16'd2;
	assign fetch_word = imem[pc[`IMEM_AW:1]];	// Byte PC to word index.

	// Load port for use while the pipeline is held.
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	// ########################################
	// PC and IF/ID valid

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `PC_RESET;
			if_id_valid <= 1'b0;
		end else if (run) begin
			if (redirect) begin
				pc <= redirect_pc;
				if_id_valid <= 1'b0;	// Squash wrong-path fetch.
			end else begin
				pc <= pc_next;
				if_id_valid <= 1'b1;
			end
		end
	end

	// IF/ID payload.
	always_ff @(posedge clk) begin
		if (run && !redirect) begin
			if_id_pc <= pc_next;
			if_id_instr <= lc3b_instr'(fetch_word);
		end
	end

endmodule

// File: regfile.sv
module regfile
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_reg dest,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

	lc3b_word data [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				data[i] <= 16'h0000;
			end
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// Write-first bypass.
	assign reg_a = (load && dest == src_a) ? in : data[src_a];
	assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule

// File: decode.sv
module decode
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic flush,
	input logic if_id_valid,
	input lc3b_word if_id_pc,
	input lc3b_instr if_id_instr,
	input logic wb_load,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	id_ex_if.producer id_ex
);

	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_word reg_a;
	lc3b_word reg_b;
	lc3b_control ctrl;

	assign src_a = if_id_instr.rform.sr1;
	assign src_b = if_id_instr.rform.sr2;

	regfile rf (
		.clk,
		.reset,
		.load(wb_load),
		.dest(wb_dest),
		.in(wb_data),
		.src_a,
		.src_b,
		.reg_a,
		.reg_b
	);

	// ########################################
	// Control decode

	always_comb begin
		ctrl.aluop = alu_pass;
		ctrl.srcb_imm_sel = 1'b0;
		ctrl.load_regfile = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.is_branch = 1'b0;

		case (if_id_instr.rform.opcode)
			op_add: begin
				ctrl.aluop = alu_add;
				ctrl.srcb_imm_sel = if_id_instr.iform.imm_flag;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_and: begin
				ctrl.aluop = alu_and;
				ctrl.srcb_imm_sel = if_id_instr.iform.imm_flag;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_br: begin
				ctrl.is_branch = 1'b1;
			end
			default: begin
				// Everything else retires as a no-op.
			end
		endcase
	end

	// ########################################
	// ID/EX stage register

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.valid <= 1'b0;
		end else if (run) begin
			id_ex.valid <= if_id_valid & ~flush;	// Drop on taken branch.
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			id_ex.pc <= if_id_pc;
			id_ex.instr <= if_id_instr;
			id_ex.ctrl <= ctrl;
			id_ex.srca <= reg_a;
			id_ex.srcb <= reg_b;
		end
	end

endmodule

// File: execute.sv
module execute
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	id_ex_if.consumer id_ex,
	output logic wb_load,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output logic redirect,
	output lc3b_word redirect_pc,
	output logic retire_valid,
	output lc3b_word retire_pc,
	output lc3b_instr retire_instr,
	output lc3b_nzp cc
);

	lc3b_word imm5_sext;
	lc3b_word opnd_b;
	lc3b_word alu_out;
	lc3b_word br_offset;
	lc3b_nzp alu_nzp;

	assign imm5_sext = {{11{id_ex.instr.iform.imm5[4]}}, id_ex.instr.iform.imm5};
	assign opnd_b = id_ex.ctrl.srcb_imm_sel ? imm5_sext : id_ex.srcb;

	// ########################################
	// ALU and condition codes

	always_comb begin
		case (id_ex.ctrl.aluop)
			alu_add: alu_out = id_ex.srca + opnd_b;
			alu_and: alu_out = id_ex.srca & opnd_b;
			alu_not: alu_out = ~id_ex.srca;
			alu_pass: alu_out = opnd_b;
		endcase
	end

	always_comb begin
		if (alu_out[15]) begin
			alu_nzp = 3'b100;
		end else if (alu_out == 16'h0000) begin
			alu_nzp = 3'b010;
		end else begin
			alu_nzp = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= 3'b010;	// Z after reset.
		end else if (id_ex.valid && id_ex.ctrl.load_cc) begin
			cc <= alu_nzp;
		end
	end

	assign wb_load = id_ex.valid & id_ex.ctrl.load_regfile;
	assign wb_dest = id_ex.instr.rform.dr;
	assign wb_data = alu_out;

	// ########################################
	// Branch resolution

	assign br_offset = {{6{id_ex.instr.br.offset9[8]}}, id_ex.instr.br.offset9, 1'b0};
	assign redirect = id_ex.valid & id_ex.ctrl.is_branch & (|(id_ex.instr.br.nzp & cc));
	assign redirect_pc = id_ex.pc + br_offset;	// PC is already plus 2.

	assign retire_valid = id_ex.valid;
	assign retire_pc = id_ex.pc - 16'd2;
	assign retire_instr = id_ex.instr;

endmodule

// File: cpu_top.sv
`include "lc3b_cfg.svh"

module cpu_top
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic imem_we,
	input logic [`IMEM_AW-1:0] imem_addr,
	input lc3b_word imem_data,
	output logic retire_valid,
	output lc3b_word retire_pc,
	output lc3b_instr retire_instr,
	output logic wb_load,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output lc3b_nzp cc
);

	logic if_id_valid;
	lc3b_word if_id_pc;
	lc3b_instr if_id_instr;
	logic redirect;
	lc3b_word redirect_pc;

	id_ex_if id_ex ();

	fetch fetch0 (
		.clk,
		.reset,
		.run,
		.imem_we,
		.imem_addr,
		.imem_data,
		.redirect,
		.redirect_pc,
		.if_id_valid,
		.if_id_pc,
		.if_id_instr
	);

	decode decode0 (
		.clk,
		.reset,
		.run,
		.flush(redirect),	// Taken branch squashes IF/ID.
		.if_id_valid,
		.if_id_pc,
		.if_id_instr,
		.wb_load,
		.wb_dest,
		.wb_data,
		.id_ex(id_ex.producer)
	);

	execute execute0 (
		.clk,
		.reset,
		.id_ex(id_ex.consumer),
		.wb_load,
		.wb_dest,
		.wb_data,
		.redirect,
		.redirect_pc,
		.retire_valid,
		.retire_pc,
		.retire_instr,
		.cc
	);

endmodule

// File: cpu_assertions.sv
`include "lc3b_cfg.svh"

module cpu_assertions
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic imem_we,
	input logic [`IMEM_AW-1:0] imem_addr,
	input lc3b_word imem_data,
	input logic retire_valid,
	input lc3b_word retire_pc,
	input lc3b_instr retire_instr,
	input logic wb_load,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	input lc3b_nzp cc,
	input logic redirect
);

	int error_count = 0;
	lc3b_word prog_copy [`IMEM_DEPTH];
	lc3b_word shadow_reg [8];
	lc3b_nzp shadow_nzp;
	lc3b_word exp_pc;
	lc3b_instr exp_instr;
	lc3b_word opnd_b;
	lc3b_word exp_result;
	lc3b_word next_pc;
	logic retire;
	logic is_alu;
	logic is_branch;
	logic br_taken;

	function automatic lc3b_nzp nzp_of(input lc3b_word w);
		if (w[15]) begin
			return 3'b100;
		end
		return (w == 16'h0000) ? 3'b010 : 3'b001;
	endfunction

	// Mirror of the instruction memory load port.
	always_ff @(posedge clk) begin
		if (imem_we) begin
			prog_copy[imem_addr] <= imem_data;
		end
	end

	assign exp_instr = lc3b_instr'(prog_copy[exp_pc[`IMEM_AW:1]]);

	assign retire = retire_valid & run;
	assign is_alu = exp_instr.rform.opcode inside {op_add, op_and, op_not};
	assign is_branch = exp_instr.rform.opcode == op_br;
	assign opnd_b = exp_instr.iform.imm_flag
		? {{11{exp_instr.iform.imm5[4]}}, exp_instr.iform.imm5}
		: shadow_reg[exp_instr.rform.sr2];

	always_comb begin
		case (exp_instr.rform.opcode)
			op_add: exp_result = shadow_reg[exp_instr.rform.sr1] + opnd_b;
			op_and: exp_result = shadow_reg[exp_instr.rform.sr1] & opnd_b;
			default: exp_result = ~shadow_reg[exp_instr.rform.sr1];
		endcase
	end

	assign br_taken = is_branch && (|(exp_instr.br.nzp & shadow_nzp));
	assign next_pc = br_taken
		? exp_pc + 16'd2 + {{6{exp_instr.br.offset9[8]}}, exp_instr.br.offset9, 1'b0}
		: exp_pc + 16'd2;

	// ########################################
	// Shadow ISA state

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				shadow_reg[i] <= 16'h0000;
			end
			shadow_nzp <= 3'b010;
			exp_pc <= `PC_RESET;
		end else if (retire) begin
			exp_pc <= next_pc;
			if (is_alu) begin
				shadow_reg[exp_instr.rform.dr] <= exp_result;
				shadow_nzp <= nzp_of(exp_result);
			end
		end
	end

	// ########################################
	// Checks

	reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid && !wb_load && !redirect)
		else begin
			error_count++;
			$error("Pipeline outputs active in the cycle after a reset edge");
		end

	retire_order: assert property (@(posedge clk) retire |-> retire_pc == exp_pc)
		else begin
			error_count++;
			$error("MISMATCH retire_pc: expected %h, actual %h", $sampled(exp_pc),
				$sampled(retire_pc));
		end

	instr_match: assert property (@(posedge clk) retire |-> retire_instr == exp_instr)
		else begin
			error_count++;
			$error("MISMATCH retire_instr: expected %h, actual %h", $sampled(exp_instr),
				$sampled(retire_instr));
		end

	alu_load: assert property (@(posedge clk) retire && is_alu |-> wb_load)
		else begin
			error_count++;
			$error("ALU instruction retired without a register write");
		end

	alu_dest: assert property (@(posedge clk)
		retire && is_alu |-> wb_dest == exp_instr.rform.dr)
		else begin
			error_count++;
			$error("MISMATCH wb_dest: expected %0d, actual %0d",
				$sampled(exp_instr.rform.dr), $sampled(wb_dest));
		end

	alu_data: assert property (@(posedge clk) retire && is_alu |-> wb_data == exp_result)
		else begin
			error_count++;
			$error("MISMATCH wb_data: expected %h, actual %h", $sampled(exp_result),
				$sampled(wb_data));
		end

	nop_load: assert property (@(posedge clk) retire && !is_alu |-> !wb_load)
		else begin
			error_count++;
			$error("Non-ALU instruction wrote the register file");
		end

	cc_alu: assert property (@(posedge clk) retire && is_alu |=> cc == shadow_nzp)
		else begin
			error_count++;
			$error("MISMATCH cc_after_alu: expected %b, actual %b", $sampled(shadow_nzp),
				$sampled(cc));
		end

	cc_hold: assert property (@(posedge clk) retire && !is_alu |=> cc == shadow_nzp)
		else begin
			error_count++;
			$error("MISMATCH cc_hold: expected %b, actual %b", $sampled(shadow_nzp),
				$sampled(cc));
		end

	branch_taken: assert property (@(posedge clk) retire && is_branch |-> redirect == br_taken)
		else begin
			error_count++;
			$error("MISMATCH branch_taken: expected %b, actual %b", $sampled(br_taken),
				$sampled(redirect));
		end

endmodule

bind cpu_top cpu_assertions chk0 (
	.clk(clk),
	.reset(reset),
	.run(run),
	.imem_we(imem_we),
	.imem_addr(imem_addr),
	.imem_data(imem_data),
	.retire_valid(retire_valid),
	.retire_pc(retire_pc),
	.retire_instr(retire_instr),
	.wb_load(wb_load),
	.wb_dest(wb_dest),
	.wb_data(wb_data),
	.cc(cc),
	.redirect(redirect)
);

// File: tb_cpu.sv
`include "lc3b_cfg.svh"

module tb_cpu
	import lc3b_types::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 2;
	localparam int SEED_LEN = 8;
	localparam int RAND_LEN = 200;
	localparam int PROG_LEN = SEED_LEN + RAND_LEN + 1;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN + PROG_LEN * 4;
	localparam lc3b_word LAST_PC = lc3b_word'(2 * (PROG_LEN - 1));

	logic clk;
	logic reset;
	logic run;
	logic imem_we;
	logic [`IMEM_AW-1:0] imem_addr;
	lc3b_word imem_data;
	logic retire_valid;
	lc3b_word retire_pc;
	lc3b_instr retire_instr;
	logic wb_load;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp cc;

	logic [31:0] lfsr = 32'h181e_369c;
	lc3b_word prog [PROG_LEN];
	int retired = 0;
	int final_hits = 0;
	int errors;

	cpu_top dut0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.wb_load(wb_load),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR stepped once per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic lc3b_opcode pick_unsupported(input logic [1:0] sel);
		case (sel)
			2'd0: return op_ldr;
			2'd1: return op_lea;
			2'd2: return op_shf;
			default: return op_jmp;
		endcase
	endfunction

	// ########################################
	// Program image

	task automatic build_program();
		logic [31:0] kind;
		logic [31:0] f;
		logic [31:0] g;
		int off;
		for (int i = 0; i < SEED_LEN; i++) begin
			f = rand_bits(5);
			prog[i] = {op_add, 3'(i), 3'(i), 1'b1, f[4:0]};	// Seed each register.
		end
		for (int i = SEED_LEN; i < PROG_LEN - 1; i++) begin
			kind = rand_bits(3);
			f = rand_bits(12);
			case (kind[2:0])
				3'd0: prog[i] = {op_add, f[11:9], f[8:6], 3'b000, f[2:0]};
				3'd1, 3'd7: prog[i] = {op_add, f[11:9], f[8:6], 1'b1, f[4:0]};
				3'd2: prog[i] = {op_and, f[11:9], f[8:6], 3'b000, f[2:0]};
				3'd3: prog[i] = {op_and, f[11:9], f[8:6], 1'b1, f[4:0]};
				3'd4: prog[i] = {op_not, f[11:9], f[8:6], 6'b111111};
				3'd5: begin
					off = int'(f[1:0]);
					if (off > PROG_LEN - 2 - i) begin
						off = PROG_LEN - 2 - i;	// Never past the final branch.
					end
					prog[i] = {op_br, f[11:9], 9'(off)};
				end
				default: begin
					g = rand_bits(2);
					prog[i] = {pick_unsupported(g[1:0]), f[11:0]};
				end
			endcase
		end
		prog[PROG_LEN - 1] = {op_br, 3'b111, 9'h1ff};	// Branch to self.
	endtask

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= i[`IMEM_AW-1:0];
			imem_data <= prog[i];
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	always @(negedge clk) begin
		if (run && retire_valid) begin
			retired++;
			if (retire_pc == LAST_PC) begin
				final_hits++;
			end
		end
	end

	// ########################################
	// Main sequence

	initial begin
		reset = 1'b1;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		load_program();
		@(posedge clk);
		run <= 1'b1;
		while (final_hits < 2) begin
			@(negedge clk);
		end
		repeat (2) @(posedge clk);	// Let the last checks complete.
		@(negedge clk);
		errors = dut0.chk0.error_count;
		$display("Retired %0d instructions, %0d assertion failures", retired, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the final branch did not retire within %0d cycles",
			WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
lc3b_types.sv
id_ex_if.sv
fetch.sv
regfile.sv
decode.sv
execute.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_MSG ?= Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
